/* src/mips_pkg.sv */
package mips_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	localparam int NUM_REGS = 32;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	// opcode and funct fields
	typedef logic [5:0]  op_field_t;

	////////////////////////////////////////
	// decode selectors
	////////////////////////////////////////

	// register field feeding an operand port
	typedef enum logic [1:0] {
		OPND_NONE = 2'b00,
		OPND_RS   = 2'b01,
		OPND_RT   = 2'b10
	} opnd_sel_t;

	// destination register field
	typedef enum logic [1:0] {
		DST_NONE = 2'b00,
		DST_RT   = 2'b10,
		DST_RD   = 2'b11
	} dst_sel_t;

	typedef enum logic [3:0] {
		ALU_AND = 4'b0000,
		ALU_OR  = 4'b0001,
		ALU_ADD = 4'b0010,
		ALU_XOR = 4'b0011,
		ALU_NOR = 4'b0100,
		ALU_SRL = 4'b0101,
		ALU_SUB = 4'b0110,
		ALU_SLT = 4'b0111,
		ALU_SLL = 4'b1000
	} alu_op_t;

	typedef enum logic [3:0] {
		HILO_NONE,
		HILO_MTHI,
		HILO_MTLO,
		HILO_MULT,
		HILO_MULTU,
		HILO_MADD,
		HILO_MADDU,
		HILO_MSUB,
		HILO_MSUBU
	} hilo_op_t;

	// where the write-back value comes from
	typedef enum logic [2:0] {
		RES_ALU,
		RES_HI,
		RES_LO,
		RES_MUL_LO,
		RES_LUI
	} res_src_t;

endpackage

/* src/inst_decode.sv */
`timescale 1ns/100ps

module inst_decode import mips_pkg::*; (
	input  word_t     inst,
	output opnd_sel_t rega_sel,
	output opnd_sel_t regb_sel,
	output logic      use_imm,
	output logic      imm_sign,
	output logic      res_signed,
	output alu_op_t   alu_op,
	output hilo_op_t  hilo_op,
	output res_src_t  res_src,
	output logic      mem_rd,
	output logic      mem_we,
	output logic      wb_we,
	output dst_sel_t  dst_sel,
	output logic      syscall,
	output logic      unknown
);

	op_field_t op;
	op_field_t fn;
	reg_addr_t rs;
	logic      r_type, special2, cop0;

	logic is_sll, is_srl, is_jr, is_jalr, is_syscall;
	logic is_mfhi, is_mthi, is_mflo, is_mtlo, is_mult, is_multu;
	logic is_add, is_addu, is_sub, is_subu;
	logic is_and, is_or, is_xor, is_nor, is_slt, is_sltu;
	logic is_j, is_jal, is_beq, is_bne;
	logic is_addi, is_addiu, is_slti, is_sltiu, is_andi, is_ori, is_xori, is_lui;
	logic is_mfc0, is_mtc0, is_eret;
	logic is_madd, is_maddu, is_mul, is_msub, is_msubu;
	logic is_lw, is_sw, is_cache;
	logic arith, bitwise, itype, mul_wb, mul_rd;

	assign op = inst[31:26];
	assign rs = inst[25:21];
	assign fn = inst[5:0];

	assign r_type   = (op == 6'h00);
	assign special2 = (op == 6'h1c);
	assign cop0     = (op == 6'h10);

	////////////////////////////////////////
	// instruction recognition
	////////////////////////////////////////

	// SPECIAL, selected by funct
	assign is_sll     = r_type & (fn == 6'h00);
	assign is_srl     = r_type & (fn == 6'h02);
	assign is_jr      = r_type & (fn == 6'h08);
	assign is_jalr    = r_type & (fn == 6'h09);
	assign is_syscall = r_type & (fn == 6'h0c);
	assign is_mfhi    = r_type & (fn == 6'h10);
	assign is_mthi    = r_type & (fn == 6'h11);
	assign is_mflo    = r_type & (fn == 6'h12);
	assign is_mtlo    = r_type & (fn == 6'h13);
	assign is_mult    = r_type & (fn == 6'h18);
	assign is_multu   = r_type & (fn == 6'h19);
	assign is_add     = r_type & (fn == 6'h20);
	assign is_addu    = r_type & (fn == 6'h21);
	assign is_sub     = r_type & (fn == 6'h22);
	assign is_subu    = r_type & (fn == 6'h23);
	assign is_and     = r_type & (fn == 6'h24);
	assign is_or      = r_type & (fn == 6'h25);
	assign is_xor     = r_type & (fn == 6'h26);
	assign is_nor     = r_type & (fn == 6'h27);
	assign is_slt     = r_type & (fn == 6'h2a);
	assign is_sltu    = r_type & (fn == 6'h2b);

	// primary opcodes
	assign is_j     = (op == 6'h02);
	assign is_jal   = (op == 6'h03);
	assign is_beq   = (op == 6'h04);
	assign is_bne   = (op == 6'h05);
	assign is_addi  = (op == 6'h08);
	assign is_addiu = (op == 6'h09);
	assign is_slti  = (op == 6'h0a);
	assign is_sltiu = (op == 6'h0b);
	assign is_andi  = (op == 6'h0c);
	assign is_ori   = (op == 6'h0d);
	assign is_xori  = (op == 6'h0e);
	assign is_lui   = (op == 6'h0f);
	assign is_lw    = (op == 6'h23);
	assign is_sw    = (op == 6'h2b);
	assign is_cache = (op == 6'h2f);

	// coprocessor 0, selected by rs
	assign is_mfc0 = cop0 & (rs == 5'h00);
	assign is_mtc0 = cop0 & (rs == 5'h04);
	assign is_eret = cop0 & (rs == 5'h10) & (fn == 6'h18);

	// SPECIAL2 multiply group
	assign is_madd  = special2 & (fn == 6'h00);
	assign is_maddu = special2 & (fn == 6'h01);
	assign is_mul   = special2 & (fn == 6'h02);
	assign is_msub  = special2 & (fn == 6'h04);
	assign is_msubu = special2 & (fn == 6'h05);

	assign unknown = ~|{is_sll, is_srl, is_jr, is_jalr, is_syscall,
		is_mfhi, is_mthi, is_mflo, is_mtlo, is_mult, is_multu,
		is_add, is_addu, is_sub, is_subu,
		is_and, is_or, is_xor, is_nor, is_slt, is_sltu,
		is_j, is_jal, is_beq, is_bne,
		is_addi, is_addiu, is_slti, is_sltiu, is_andi, is_ori, is_xori, is_lui,
		is_mfc0, is_mtc0, is_eret,
		is_madd, is_maddu, is_mul, is_msub, is_msubu,
		is_lw, is_sw, is_cache};

	// instruction classes
	assign arith   = |{is_add, is_addu, is_sub, is_subu};
	assign bitwise = |{is_slt, is_and, is_or, is_xor, is_nor};
	assign itype   = |{is_addi, is_addiu, is_andi, is_ori, is_slti, is_xori};
	assign mul_wb  = |{is_mul, is_mfhi, is_mflo};
	assign mul_rd  = |{is_mult, is_multu, is_mul, is_madd, is_maddu, is_msub, is_msubu};

	////////////////////////////////////////
	// steering controls
	////////////////////////////////////////

	assign use_imm    = |{itype, is_srl, is_sll, is_lw, is_sw};
	assign imm_sign   = |{is_lw, is_sw, is_addi, is_addiu, is_slti};
	assign res_signed = |{is_add, is_sub, is_addi};
	assign mem_rd     = is_lw;
	assign mem_we     = is_sw;
	assign syscall    = is_syscall;
	// lw has no load return, so it writes nothing
	assign wb_we      = |{arith, bitwise, itype, mul_wb, is_srl, is_sll, is_lui};

	always_comb begin
		// shifts work on rt through port a
		if (|{arith, bitwise, itype, mul_rd, is_mthi, is_mtlo, is_lw, is_sw})
			rega_sel = OPND_RS;
		else if (is_srl | is_sll)
			rega_sel = OPND_RT;
		else
			rega_sel = OPND_NONE;

		regb_sel = (|{arith, bitwise, mul_rd, is_sw}) ? OPND_RT : OPND_NONE;

		if (|{itype, is_lui})
			dst_sel = DST_RT;
		else if (|{arith, bitwise, mul_wb, is_srl, is_sll})
			dst_sel = DST_RD;
		else
			dst_sel = DST_NONE;
	end

	always_comb begin
		if (|{is_add, is_addu, is_lw, is_sw, is_addi, is_addiu})
			alu_op = ALU_ADD;
		else if (is_sub | is_subu)
			alu_op = ALU_SUB;
		else if (is_slt | is_slti)
			alu_op = ALU_SLT;
		else if (is_or | is_ori)
			alu_op = ALU_OR;
		else if (is_xor | is_xori)
			alu_op = ALU_XOR;
		else if (is_nor)
			alu_op = ALU_NOR;
		else if (is_srl)
			alu_op = ALU_SRL;
		else if (is_sll)
			alu_op = ALU_SLL;
		else
			alu_op = ALU_AND;

		if (is_mfhi)
			res_src = RES_HI;
		else if (is_mflo)
			res_src = RES_LO;
		else if (is_mul)
			res_src = RES_MUL_LO;
		else if (is_lui)
			res_src = RES_LUI;
		else
			res_src = RES_ALU;
	end

	// mul itself leaves HI/LO alone
	always_comb begin
		if (is_mthi)
			hilo_op = HILO_MTHI;
		else if (is_mtlo)
			hilo_op = HILO_MTLO;
		else if (is_mult)
			hilo_op = HILO_MULT;
		else if (is_multu)
			hilo_op = HILO_MULTU;
		else if (is_madd)
			hilo_op = HILO_MADD;
		else if (is_maddu)
			hilo_op = HILO_MADDU;
		else if (is_msub)
			hilo_op = HILO_MSUB;
		else if (is_msubu)
			hilo_op = HILO_MSUBU;
		else
			hilo_op = HILO_NONE;
	end

endmodule

/* src/reg_file.sv */
`timescale 1ns/100ps

module reg_file import mips_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  reg_addr_t ra_addr,
	input  reg_addr_t rb_addr,
	input  reg_addr_t wr_addr,
	input  logic      wr_en,
	input  word_t     wr_data,
	output word_t     ra_data,
	output word_t     rb_data
);

	word_t regs [NUM_REGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// register 0 is hard-wired
	assign ra_data = (ra_addr == '0) ? '0 : regs[ra_addr];
	assign rb_data = (rb_addr == '0) ? '0 : regs[rb_addr];

endmodule

/* src/alu.sv */
`timescale 1ns/100ps

module alu import mips_pkg::*; (
	input  word_t      a,
	input  word_t      b,
	input  logic [4:0] shamt,
	input  alu_op_t    op,
	output word_t      result,
	output logic       overflow
);

	word_t sum;
	word_t diff;
	logic  add_ovf;
	logic  sub_ovf;

	assign sum  = a + b;
	assign diff = a - b;

	// signed overflow: sign of result disagrees with the operands
	assign add_ovf = (a[31] == b[31]) && (sum[31] != a[31]);
	assign sub_ovf = (a[31] != b[31]) && (diff[31] != a[31]);

	always_comb begin
		overflow = 1'b0;
		case (op)
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_NOR: result = ~(a | b);
			ALU_ADD: begin
				result   = sum;
				overflow = add_ovf;
			end
			ALU_SUB: begin
				result   = diff;
				overflow = sub_ovf;
			end
			ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
			// shifts act on a, which carries rt
			ALU_SLL: result = a << shamt;
			ALU_SRL: result = a >> shamt;
			default: result = '0;
		endcase
	end

endmodule

/* src/hilo_unit.sv */
`timescale 1ns/100ps

module hilo_unit import mips_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     en,
	input  hilo_op_t op,
	input  word_t    a,
	input  word_t    b,
	output word_t    hi,
	output word_t    lo,
	output word_t    mul_lo
);

	logic [63:0] prod_s;
	logic [63:0] prod_u;
	logic [63:0] acc;

	assign prod_s = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
	assign prod_u = {32'b0, a} * {32'b0, b};
	assign acc    = {hi, lo};

	// mul result goes straight to write-back
	assign mul_lo = prod_s[31:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hi <= '0;
			lo <= '0;
		end else if (en) begin
			case (op)
				HILO_MTHI:  hi <= a;
				HILO_MTLO:  lo <= a;
				HILO_MULT:  {hi, lo} <= prod_s;
				HILO_MULTU: {hi, lo} <= prod_u;
				HILO_MADD:  {hi, lo} <= acc + prod_s;
				HILO_MADDU: {hi, lo} <= acc + prod_u;
				HILO_MSUB:  {hi, lo} <= acc - prod_s;
				HILO_MSUBU: {hi, lo} <= acc - prod_u;
				default: ;
			endcase
		end
	end

endmodule

/* src/exec_core.sv */
`timescale 1ns/100ps

module exec_core import mips_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      inst_valid,
	input  word_t     inst,
	output logic      wb_valid,
	output reg_addr_t wb_addr,
	output word_t     wb_data,
	output logic      mem_rd,
	output logic      mem_we,
	output word_t     mem_addr,
	output word_t     mem_wdata,
	output logic      exc_syscall,
	output logic      exc_unknown,
	output logic      exc_overflow
);

	reg_addr_t  rs, rt, rd;
	logic [15:0] imm;
	opnd_sel_t  rega_sel, regb_sel;
	dst_sel_t   dst_sel;
	alu_op_t    alu_op;
	hilo_op_t   hilo_op;
	res_src_t   res_src;
	logic       use_imm, imm_sign, res_signed, wb_we;
	logic       id_mem_rd, id_mem_we, id_syscall, id_unknown;
	reg_addr_t  ra_addr, rb_addr, dst_addr;
	word_t      ra_data, rb_data, imm_ext, alu_b, alu_res;
	word_t      hi, lo, mul_lo, res;
	logic       alu_ovf, ovf_hit, wr_en;

	function automatic reg_addr_t pick_reg(input opnd_sel_t sel, input reg_addr_t rs_f,
			input reg_addr_t rt_f);
		case (sel)
			OPND_RS: return rs_f;
			OPND_RT: return rt_f;
			default: return '0;
		endcase
	endfunction

	assign rs  = inst[25:21];
	assign rt  = inst[20:16];
	assign rd  = inst[15:11];
	assign imm = inst[15:0];

	inst_decode u_decode (
		.inst       (inst),
		.rega_sel   (rega_sel),
		.regb_sel   (regb_sel),
		.use_imm    (use_imm),
		.imm_sign   (imm_sign),
		.res_signed (res_signed),
		.alu_op     (alu_op),
		.hilo_op    (hilo_op),
		.res_src    (res_src),
		.mem_rd     (id_mem_rd),
		.mem_we     (id_mem_we),
		.wb_we      (wb_we),
		.dst_sel    (dst_sel),
		.syscall    (id_syscall),
		.unknown    (id_unknown)
	);

	assign ra_addr = pick_reg(rega_sel, rs, rt);
	assign rb_addr = pick_reg(regb_sel, rs, rt);

	reg_file u_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.ra_addr (ra_addr),
		.rb_addr (rb_addr),
		.wr_addr (dst_addr),
		.wr_en   (wr_en),
		.wr_data (res),
		.ra_data (ra_data),
		.rb_data (rb_data)
	);

	////////////////////////////////////////
	// execute
	////////////////////////////////////////

	assign imm_ext = imm_sign ? {{16{imm[15]}}, imm} : {16'b0, imm};
	assign alu_b   = use_imm ? imm_ext : rb_data;

	alu u_alu (
		.a        (ra_data),
		.b        (alu_b),
		.shamt    (inst[10:6]),
		.op       (alu_op),
		.result   (alu_res),
		.overflow (alu_ovf)
	);

	// HI/LO only moves for a valid instruction
	hilo_unit u_hilo (
		.clk    (clk),
		.rst_n  (rst_n),
		.en     (inst_valid),
		.op     (hilo_op),
		.a      (ra_data),
		.b      (rb_data),
		.hi     (hi),
		.lo     (lo),
		.mul_lo (mul_lo)
	);

	always_comb begin
		case (res_src)
			RES_HI:     res = hi;
			RES_LO:     res = lo;
			RES_MUL_LO: res = mul_lo;
			RES_LUI:    res = {imm, 16'b0};
			default:    res = alu_res;
		endcase

		case (dst_sel)
			DST_RT:  dst_addr = rt;
			DST_RD:  dst_addr = rd;
			default: dst_addr = '0;
		endcase
	end

	////////////////////////////////////////
	// write-back and output stage
	////////////////////////////////////////

	// only add, sub and addi trap on overflow
	assign ovf_hit = inst_valid & res_signed & alu_ovf;
	assign wr_en   = inst_valid & wb_we & ~(ovf_hit | id_syscall | id_unknown);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid     <= 1'b0;
			mem_rd       <= 1'b0;
			mem_we       <= 1'b0;
			exc_syscall  <= 1'b0;
			exc_unknown  <= 1'b0;
			exc_overflow <= 1'b0;
		end else begin
			wb_valid     <= wr_en;
			mem_rd       <= inst_valid & id_mem_rd;
			mem_we       <= inst_valid & id_mem_we;
			exc_syscall  <= inst_valid & id_syscall;
			exc_unknown  <= inst_valid & id_unknown;
			exc_overflow <= ovf_hit;
		end
	end

	// payload follows the current instruction every cycle
	always_ff @(posedge clk) begin
		wb_addr   <= dst_addr;
		wb_data   <= res;
		mem_addr  <= alu_res;
		mem_wdata <= rb_data;
	end

endmodule

/* sim/exec_core_props.sv */
`timescale 1ns/100ps

module exec_core_props (
	input logic clk,
	input logic rst_n,
	input logic wb_valid,
	input logic mem_rd,
	input logic mem_we,
	input logic exc_syscall,
	input logic exc_unknown,
	input logic exc_overflow
);

	logic any_exc;

	assign any_exc = exc_syscall | exc_unknown | exc_overflow;

	// nothing issued yet, so every strobe stays low
	quiet_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |=> !(wb_valid | mem_rd | mem_we | any_exc))
		else $error("output strobe in the cycle after reset release");

	wb_without_exc: assert property (@(posedge clk) disable iff (!rst_n)
		!(wb_valid && any_exc))
		else $error("write-back together with an exception pulse");

	wb_without_store: assert property (@(posedge clk) disable iff (!rst_n)
		!(wb_valid && mem_we))
		else $error("write-back together with a store request");

endmodule

bind exec_core exec_core_props u_props (
	.clk          (clk),
	.rst_n        (rst_n),
	.wb_valid     (wb_valid),
	.mem_rd       (mem_rd),
	.mem_we       (mem_we),
	.exc_syscall  (exc_syscall),
	.exc_unknown  (exc_unknown),
	.exc_overflow (exc_overflow)
);

/* sim/exec_core_tb.sv */
`timescale 1ns/100ps

module exec_core_tb import mips_pkg::*; ();

	localparam int COLS      = 11;
	localparam int MAX_VECS  = 64;
	localparam int IDLE_WAIT = 8;

	// column order in the stim file
	localparam int C_INST      = 0;
	localparam int C_WB_VALID  = 1;
	localparam int C_WB_ADDR   = 2;
	localparam int C_WB_DATA   = 3;
	localparam int C_MEM_RD    = 4;
	localparam int C_MEM_WE    = 5;
	localparam int C_MEM_ADDR  = 6;
	localparam int C_MEM_WDATA = 7;
	localparam int C_SYSCALL   = 8;
	localparam int C_UNKNOWN   = 9;
	localparam int C_OVERFLOW  = 10;

	logic      clk;
	logic      rst_n;
	logic      inst_valid;
	word_t     inst;
	logic      wb_valid;
	reg_addr_t wb_addr;
	word_t     wb_data;
	logic      mem_rd;
	logic      mem_we;
	word_t     mem_addr;
	word_t     mem_wdata;
	logic      exc_syscall;
	logic      exc_unknown;
	logic      exc_overflow;

	// word 0 is the vector count, then COLS words per vector
	word_t stim [0:COLS*MAX_VECS];
	int    num_vecs;

	exec_core uut (
		.clk          (clk),
		.rst_n        (rst_n),
		.inst_valid   (inst_valid),
		.inst         (inst),
		.wb_valid     (wb_valid),
		.wb_addr      (wb_addr),
		.wb_data      (wb_data),
		.mem_rd       (mem_rd),
		.mem_we       (mem_we),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.exc_syscall  (exc_syscall),
		.exc_unknown  (exc_unknown),
		.exc_overflow (exc_overflow)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp)
			abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
		if (act !== exp)
			abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("Error: %s expected %b actual %b", name, exp, act));
	endtask

	// payload fields only matter while their strobe is expected
	task automatic check_outputs(input int v);
		word_t row [COLS];
		string tag;
		for (int c = 0; c < COLS; c++)
			row[c] = stim[1 + v * COLS + c];
		tag = $sformatf("vector %0d inst %h", v, row[C_INST]);
		check_bit({tag, " wb_valid"}, row[C_WB_VALID][0], wb_valid);
		if (row[C_WB_VALID][0]) begin
			check_addr({tag, " wb_addr"}, row[C_WB_ADDR][4:0], wb_addr);
			check_word({tag, " wb_data"}, row[C_WB_DATA], wb_data);
		end
		check_bit({tag, " mem_rd"}, row[C_MEM_RD][0], mem_rd);
		check_bit({tag, " mem_we"}, row[C_MEM_WE][0], mem_we);
		if (row[C_MEM_RD][0] | row[C_MEM_WE][0])
			check_word({tag, " mem_addr"}, row[C_MEM_ADDR], mem_addr);
		if (row[C_MEM_WE][0])
			check_word({tag, " mem_wdata"}, row[C_MEM_WDATA], mem_wdata);
		check_bit({tag, " exc_syscall"}, row[C_SYSCALL][0], exc_syscall);
		check_bit({tag, " exc_unknown"}, row[C_UNKNOWN][0], exc_unknown);
		check_bit({tag, " exc_overflow"}, row[C_OVERFLOW][0], exc_overflow);
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		int idle_cycles;
		rst_n      = 1'b0;
		inst_valid = 1'b0;
		inst       = '0;
		$readmemh("sim/exec_core_stim.txt", stim);
		num_vecs = int'(stim[0]);
		if (num_vecs < 1 || num_vecs > MAX_VECS)
			abort_run("stim file does not hold a usable vector count");

		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		// back to back, each result checked one cycle after issue
		for (int v = 0; v < num_vecs; v++) begin
			if (v > 0)
				check_outputs(v - 1);
			inst_valid = 1'b1;
			inst       = stim[1 + v * COLS + C_INST];
			@(negedge clk);
		end
		inst_valid = 1'b0;
		inst       = '0;
		check_outputs(num_vecs - 1);

		// strobes must drop once nothing is issued
		@(negedge clk);
		idle_cycles = 0;
		while ((wb_valid | mem_rd | mem_we | exc_syscall | exc_unknown | exc_overflow)
				&& idle_cycles < IDLE_WAIT) begin
			@(negedge clk);
			idle_cycles++;
		end
		if (wb_valid | mem_rd | mem_we | exc_syscall | exc_unknown | exc_overflow) begin
			abort_run("outputs did not go idle after the last instruction");
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

/* sim/exec_core_stim.txt */
// first word: vector count (hex), then one vector per line
// inst wb_valid wb_addr wb_data mem_rd mem_we mem_addr mem_wdata exc_syscall exc_unknown exc_overflow
2b
24011234 1 01 00001234 0 0 00000000 00000000 0 0 0
2402fffe 1 02 fffffffe 0 0 00000000 00000000 0 0 0
34038001 1 03 00008001 0 0 00000000 00000000 0 0 0
3c047fff 1 04 7fff0000 0 0 00000000 00000000 0 0 0
3484ffff 1 04 7fffffff 0 0 00000000 00000000 0 0 0
304500f0 1 05 000000f0 0 0 00000000 00000000 0 0 0
3866ffff 1 06 00007ffe 0 0 00000000 00000000 0 0 0
2847ffff 1 07 00000001 0 0 00000000 00000000 0 0 0
00234020 1 08 00009235 0 0 00000000 00000000 0 0 0
00224823 1 09 00001236 0 0 00000000 00000000 0 0 0
00435024 1 0a 00008000 0 0 00000000 00000000 0 0 0
00255825 1 0b 000012f4 0 0 00000000 00000000 0 0 0
00226026 1 0c ffffedca 0 0 00000000 00000000 0 0 0
00206827 1 0d ffffedcb 0 0 00000000 00000000 0 0 0
0082702a 1 0e 00000000 0 0 00000000 00000000 0 0 0
00017900 1 0f 00012340 0 0 00000000 00000000 0 0 0
00028702 1 10 0000000f 0 0 00000000 00000000 0 0 0
00210020 1 00 00002468 0 0 00000000 00000000 0 0 0
00018825 1 11 00001234 0 0 00000000 00000000 0 0 0
00410018 0 00 00000000 0 0 00000000 00000000 0 0 0
00009010 1 12 ffffffff 0 0 00000000 00000000 0 0 0
00009812 1 13 ffffdb98 0 0 00000000 00000000 0 0 0
00410019 0 00 00000000 0 0 00000000 00000000 0 0 0
70210000 0 00 00000000 0 0 00000000 00000000 0 0 0
70430005 0 00 00000000 0 0 00000000 00000000 0 0 0
00009010 1 12 ffff9233 0 0 00000000 00000000 0 0 0
7082a002 1 14 00000002 0 0 00000000 00000000 0 0 0
00009812 1 13 014c362a 0 0 00000000 00000000 0 0 0
00200011 0 00 00000000 0 0 00000000 00000000 0 0 0
00600013 0 00 00000000 0 0 00000000 00000000 0 0 0
0000a810 1 15 00001234 0 0 00000000 00000000 0 0 0
0000b012 1 16 00008001 0 0 00000000 00000000 0 0 0
ac61fffc 0 00 00000000 0 1 00007ffd 00001234 0 0 0
8cb70010 0 00 00000000 1 0 00000100 00000000 0 0 0
0084d820 0 00 00000000 0 0 00000000 00000000 0 0 1
0084c021 1 18 fffffffe 0 0 00000000 00000000 0 0 0
20990001 0 00 00000000 0 0 00000000 00000000 0 0 1
24990001 1 19 80000000 0 0 00000000 00000000 0 0 0
0360e025 1 1c 00000000 0 0 00000000 00000000 0 0 0
0000000c 0 00 00000000 0 0 00000000 00000000 1 0 0
fc000000 0 00 00000000 0 0 00000000 00000000 0 1 0
10210004 0 00 00000000 0 0 00000000 00000000 0 0 0
0022e82b 0 00 00000000 0 0 00000000 00000000 0 0 0

/* exec_core.f */
src/mips_pkg.sv
src/inst_decode.sv
src/reg_file.sv
src/alu.sv
src/hilo_unit.sv
src/exec_core.sv
sim/exec_core_props.sv
sim/exec_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the exec_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --assert -sv --top-module exec_core_tb -Mdir obj_dir -f exec_core.f; then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/Vexec_core_tb > "$LOG" 2>&1; then
	cat "$LOG"
	echo "simulation exited with an error"
	exit 1
fi
cat "$LOG"

if grep -qx '>>> PASS' "$LOG"; then
	exit 0
else
	echo "pass message not found in $LOG"
	exit 1
fi
